/* flist.f */
+incdir+include
src/rv_pkg.sv
src/inst_sequencer.sv
src/reg_file.sv
src/inst_decode.sv
src/exec_unit.sv
src/result_stage.sv
src/exec_core.sv
test/tb_exec_core.sv

/* include/rv_defs.svh */
// widths and opcode values for the rv64i execute slice, included by rtl and testbench
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and address width
`define XLEN_W 64

// register index width, 32 architectural registers
`define REG_ADDR_W 5

// major opcodes, inst[6:0]
`define OPC_AUIPC     7'b0010111
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP_32     7'b0111011
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011

`endif

/* src/exec_core.sv */
// top of the execute slice, takes one strobed instruction at a time and retires it
`include "rv_defs.svh"
`default_nettype none

module exec_core (
  input  wire logic                   clk,
  input  wire logic                   rst_n_i,
  input  wire logic                   inst_valid_i,
  input  wire logic [31:0]            inst_i,
  input  wire logic [`XLEN_W-1:0]     pc_i,
  input  wire logic [`REG_ADDR_W-1:0] dbg_addr_i,
  output logic                        busy_o,
  output logic                        retire_o,
  output logic                        rd_we_o,
  output logic      [`REG_ADDR_W-1:0] rd_addr_o,
  output logic      [`XLEN_W-1:0]     rd_data_o,
  output logic                        jmp_o,
  output logic      [`XLEN_W-1:0]     jmp_addr_o,
  output logic      [`XLEN_W-1:0]     dbg_data_o
);

  logic                    accept;
  rv_pkg::phase_e          phase;
  logic [`REG_ADDR_W-1:0]  rs1_addr, rs2_addr;
  logic [`XLEN_W-1:0]      rs1_data, rs2_data;
  logic [`XLEN_W-1:0]      op_a, op_b, link, branch_off;
  rv_pkg::alu_op_e         alu_op;
  rv_pkg::br_cond_e        br_cond;
  rv_pkg::inst_class_e     inst_class;
  logic                    word_op;
  logic [`REG_ADDR_W-1:0]  dec_rd_addr;
  logic                    dec_rd_we;
  logic [`XLEN_W-1:0]      alu_result, target;
  logic                    taken;

  assign accept = inst_valid_i && !busy_o;  // strobes while busy are dropped

  inst_sequencer u_seq (
    .clk(clk), .rst_n_i(rst_n_i), .start_i(accept), .phase_o(phase), .busy_o(busy_o)
  );

  reg_file u_rf (
    .clk(clk), .rst_n_i(rst_n_i),
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .dbg_addr_i(dbg_addr_i),
    .we_i(rd_we_o), .wr_addr_i(rd_addr_o), .wr_data_i(rd_data_o),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .dbg_data_o(dbg_data_o)
  );

  inst_decode u_dec (
    .clk(clk), .rst_n_i(rst_n_i), .accept_i(accept), .inst_i(inst_i), .pc_i(pc_i),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .op_a_o(op_a), .op_b_o(op_b), .link_o(link), .branch_off_o(branch_off),
    .alu_op_o(alu_op), .br_cond_o(br_cond), .class_o(inst_class), .word_op_o(word_op),
    .rd_addr_o(dec_rd_addr), .rd_we_o(dec_rd_we)
  );

  exec_unit u_exe (
    .op_a_i(op_a), .op_b_i(op_b), .link_i(link), .branch_off_i(branch_off),
    .alu_op_i(alu_op), .br_cond_i(br_cond), .class_i(inst_class), .word_op_i(word_op),
    .result_o(alu_result), .taken_o(taken), .target_o(target)
  );

  result_stage u_res (
    .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase),
    .result_i(alu_result), .taken_i(taken), .target_i(target),
    .rd_we_i(dec_rd_we), .rd_addr_i(dec_rd_addr),
    .retire_o(retire_o), .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o),
    .jmp_o(jmp_o), .jmp_addr_o(jmp_addr_o)
  );

endmodule

`default_nettype wire

/* src/exec_unit.sv */
// combinational execute, alu with word forms, branch compare and redirect target
`include "rv_defs.svh"
`default_nettype none

module exec_unit (
  input  wire logic [`XLEN_W-1:0] op_a_i,
  input  wire logic [`XLEN_W-1:0] op_b_i,
  input  wire logic [`XLEN_W-1:0] link_i,
  input  wire logic [`XLEN_W-1:0] branch_off_i,
  input  wire rv_pkg::alu_op_e    alu_op_i,
  input  wire rv_pkg::br_cond_e   br_cond_i,
  input  wire rv_pkg::inst_class_e class_i,
  input  wire logic               word_op_i,
  output logic      [`XLEN_W-1:0] result_o,
  output logic                    taken_o,
  output logic      [`XLEN_W-1:0] target_o
);

  logic               is_jump;
  logic [`XLEN_W-1:0] alu_b;
  logic [`XLEN_W-1:0] res64;
  logic [31:0]        a32, b32, res32;
  logic [5:0]         sh64;
  logic [4:0]         sh32;
  logic [`XLEN_W-1:0] jump_sum;
  logic               cond;

  assign is_jump = (class_i == rv_pkg::cls_jal) || (class_i == rv_pkg::cls_jalr);
  assign alu_b   = is_jump ? link_i : op_b_i;  // pass_b returns the link

  assign a32  = op_a_i[31:0];
  assign b32  = alu_b[31:0];
  assign sh64 = alu_b[5:0];
  assign sh32 = alu_b[4:0];

  always_comb begin
    case (alu_op_i)
      rv_pkg::alu_add:    res64 = op_a_i + alu_b;
      rv_pkg::alu_sub:    res64 = op_a_i - alu_b;
      rv_pkg::alu_sll:    res64 = op_a_i << sh64;
      rv_pkg::alu_slt:    res64 = {63'b0, ($signed(op_a_i) < $signed(alu_b))};
      rv_pkg::alu_sltu:   res64 = {63'b0, (op_a_i < alu_b)};
      rv_pkg::alu_xor:    res64 = op_a_i ^ alu_b;
      rv_pkg::alu_srl:    res64 = op_a_i >> sh64;
      rv_pkg::alu_sra:    res64 = $signed(op_a_i) >>> sh64;
      rv_pkg::alu_or:     res64 = op_a_i | alu_b;
      rv_pkg::alu_and:    res64 = op_a_i & alu_b;
      rv_pkg::alu_pass_b: res64 = alu_b;
      default:            res64 = '0;
    endcase
  end

  // word forms on the low half
  always_comb begin
    case (alu_op_i)
      rv_pkg::alu_add: res32 = a32 + b32;
      rv_pkg::alu_sub: res32 = a32 - b32;
      rv_pkg::alu_sll: res32 = a32 << sh32;
      rv_pkg::alu_srl: res32 = a32 >> sh32;
      rv_pkg::alu_sra: res32 = $signed(a32) >>> sh32;
      default:         res32 = res64[31:0];
    endcase
  end

  assign result_o = word_op_i ? {{32{res32[31]}}, res32} : res64;

  always_comb begin
    case (br_cond_i)
      rv_pkg::br_eq:  cond = (op_a_i == op_b_i);
      rv_pkg::br_ne:  cond = (op_a_i != op_b_i);
      rv_pkg::br_lt:  cond = ($signed(op_a_i) < $signed(op_b_i));
      rv_pkg::br_ge:  cond = ($signed(op_a_i) >= $signed(op_b_i));
      rv_pkg::br_ltu: cond = (op_a_i < op_b_i);
      rv_pkg::br_geu: cond = (op_a_i >= op_b_i);
      default:        cond = 1'b0;
    endcase
  end

  assign jump_sum = op_a_i + op_b_i;

  always_comb begin
    case (class_i)
      rv_pkg::cls_branch: begin
        taken_o  = cond;
        target_o = link_i + branch_off_i;  // link holds pc here
      end
      rv_pkg::cls_jal: begin
        taken_o  = 1'b1;
        target_o = jump_sum;
      end
      rv_pkg::cls_jalr: begin
        taken_o  = 1'b1;
        target_o = {jump_sum[`XLEN_W-1:1], 1'b0};
      end
      default: begin
        taken_o  = 1'b0;
        target_o = link_i + branch_off_i;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/inst_decode.sv */
// instruction decode, captures operands and controls on the accepting edge for execute
`include "rv_defs.svh"
`default_nettype none

module inst_decode (
  input  wire logic                   clk,
  input  wire logic                   rst_n_i,
  input  wire logic                   accept_i,
  input  wire logic [31:0]            inst_i,
  input  wire logic [`XLEN_W-1:0]     pc_i,
  output logic      [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic      [`REG_ADDR_W-1:0] rs2_addr_o,
  input  wire logic [`XLEN_W-1:0]     rs1_data_i,
  input  wire logic [`XLEN_W-1:0]     rs2_data_i,
  output logic      [`XLEN_W-1:0]     op_a_o,
  output logic      [`XLEN_W-1:0]     op_b_o,
  output logic      [`XLEN_W-1:0]     link_o,
  output logic      [`XLEN_W-1:0]     branch_off_o,
  output rv_pkg::alu_op_e             alu_op_o,
  output rv_pkg::br_cond_e            br_cond_o,
  output rv_pkg::inst_class_e         class_o,
  output logic                        word_op_o,
  output logic      [`REG_ADDR_W-1:0] rd_addr_o,
  output logic                        rd_we_o
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [`XLEN_W-1:0]  imm_i, imm_b, imm_j, imm_u;
  logic [`XLEN_W-1:0]  op_a_d, op_b_d, link_d;
  rv_pkg::alu_op_e     alu_op_d;
  rv_pkg::inst_class_e class_d;
  logic                word_d, we_d;

  // funct3 to alu op; alt is inst[30], sub only exists for register forms
  function automatic rv_pkg::alu_op_e alu_fn(input logic [2:0] f3, input logic alt,
                                             input logic imm);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = (alt && !imm) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  op = rv_pkg::alu_sll;
      3'b010:  op = rv_pkg::alu_slt;
      3'b011:  op = rv_pkg::alu_sltu;
      3'b100:  op = rv_pkg::alu_xor;
      3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  op = rv_pkg::alu_or;
      default: op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign opcode     = inst_i[6:0];
  assign funct3     = inst_i[14:12];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};

  always_comb begin
    op_a_d   = rs1_data_i;
    op_b_d   = imm_i;
    link_d   = pc_i + `XLEN_W'(4);
    alu_op_d = rv_pkg::alu_add;
    class_d  = rv_pkg::cls_alu;
    word_d   = 1'b0;
    we_d     = 1'b0;
    case (opcode)
      `OPC_AUIPC: begin
        op_a_d = pc_i;
        op_b_d = imm_u;
        we_d   = 1'b1;
      end
      `OPC_OP_IMM: begin
        alu_op_d = alu_fn(funct3, inst_i[30], 1'b1);
        if (funct3[1:0] == 2'b01) begin
          op_b_d = {{(`XLEN_W-6){1'b0}}, inst_i[25:20]};  // 6-bit shamt
        end
        we_d = 1'b1;
      end
      `OPC_OP: begin
        op_b_d   = rs2_data_i;
        alu_op_d = alu_fn(funct3, inst_i[30], 1'b0);
        we_d     = 1'b1;
      end
      `OPC_OP_IMM_32: begin
        alu_op_d = alu_fn(funct3, inst_i[30], 1'b1);
        if (funct3[1:0] == 2'b01) begin
          op_b_d = {{(`XLEN_W-5){1'b0}}, inst_i[24:20]};
        end
        word_d = 1'b1;
        we_d   = 1'b1;
      end
      `OPC_OP_32: begin
        op_b_d   = rs2_data_i;
        alu_op_d = alu_fn(funct3, inst_i[30], 1'b0);
        word_d   = 1'b1;
        we_d     = 1'b1;
      end
      `OPC_JAL: begin
        op_a_d   = pc_i;
        op_b_d   = imm_j;
        alu_op_d = rv_pkg::alu_pass_b;
        class_d  = rv_pkg::cls_jal;
        we_d     = 1'b1;
      end
      `OPC_JALR: begin
        alu_op_d = rv_pkg::alu_pass_b;
        class_d  = rv_pkg::cls_jalr;
        we_d     = 1'b1;
      end
      `OPC_BRANCH: begin
        op_b_d = rs2_data_i;
        link_d = pc_i;  // base of the branch target
        if (funct3[2:1] != 2'b01) begin
          class_d = rv_pkg::cls_branch;
        end
      end
      default: ;  // unsupported, retires as a no-op
    endcase
  end

  // controls
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_op_o  <= rv_pkg::alu_add;
      br_cond_o <= rv_pkg::br_eq;
      class_o   <= rv_pkg::cls_alu;
      word_op_o <= 1'b0;
      rd_we_o   <= 1'b0;
    end else if (accept_i) begin
      alu_op_o  <= alu_op_d;
      br_cond_o <= rv_pkg::br_cond_e'(funct3);  // only read for valid branch funct3
      class_o   <= class_d;
      word_op_o <= word_d;
      rd_we_o   <= we_d;
    end
  end

  // operand set
  always_ff @(posedge clk) begin
    if (accept_i) begin
      op_a_o       <= op_a_d;
      op_b_o       <= op_b_d;
      link_o       <= link_d;
      branch_off_o <= imm_b;
      rd_addr_o    <= inst_i[11:7];
    end
  end

endmodule

`default_nettype wire

/* src/inst_sequencer.sv */
// phase counter of the execute slice, started by an accepted instruction strobe
`default_nettype none

module inst_sequencer (
  input  wire logic      clk,
  input  wire logic      rst_n_i,
  input  wire logic      start_i,
  output rv_pkg::phase_e phase_o,
  output logic           busy_o
);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_o <= rv_pkg::ph_idle;
    end else begin
      case (phase_o)
        rv_pkg::ph_idle: begin
          if (start_i) begin
            phase_o <= rv_pkg::ph_execute;
          end
        end
        rv_pkg::ph_execute: begin
          phase_o <= rv_pkg::ph_writeback;
        end
        default: begin
          phase_o <= rv_pkg::ph_idle;  // writeback and the unused code
        end
      endcase
    end
  end

  assign busy_o = (phase_o != rv_pkg::ph_idle);

endmodule

`default_nettype wire

/* src/reg_file.sv */
// integer register file with two operand reads, a debug read and one write port
`include "rv_defs.svh"
`default_nettype none

module reg_file (
  input  wire logic                   clk,
  input  wire logic                   rst_n_i,
  input  wire logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  wire logic [`REG_ADDR_W-1:0] rs2_addr_i,
  input  wire logic [`REG_ADDR_W-1:0] dbg_addr_i,
  input  wire logic                   we_i,
  input  wire logic [`REG_ADDR_W-1:0] wr_addr_i,
  input  wire logic [`XLEN_W-1:0]     wr_data_i,
  output logic      [`XLEN_W-1:0]     rs1_data_o,
  output logic      [`XLEN_W-1:0]     rs2_data_o,
  output logic      [`XLEN_W-1:0]     dbg_data_o
);

  logic [`XLEN_W-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_addr_i != '0) ? regs[rs1_addr_i] : '0;
  assign rs2_data_o = (rs2_addr_i != '0) ? regs[rs2_addr_i] : '0;
  assign dbg_data_o = (dbg_addr_i != '0) ? regs[dbg_addr_i] : '0;

endmodule

`default_nettype wire

/* src/result_stage.sv */
// result register, presents write-back, retire and redirect for the writeback cycle
`include "rv_defs.svh"
`default_nettype none

module result_stage (
  input  wire logic                   clk,
  input  wire logic                   rst_n_i,
  input  wire rv_pkg::phase_e         phase_i,
  input  wire logic [`XLEN_W-1:0]     result_i,
  input  wire logic                   taken_i,
  input  wire logic [`XLEN_W-1:0]     target_i,
  input  wire logic                   rd_we_i,
  input  wire logic [`REG_ADDR_W-1:0] rd_addr_i,
  output logic                        retire_o,
  output logic                        rd_we_o,
  output logic      [`REG_ADDR_W-1:0] rd_addr_o,
  output logic      [`XLEN_W-1:0]     rd_data_o,
  output logic                        jmp_o,
  output logic      [`XLEN_W-1:0]     jmp_addr_o
);

  logic ex_end;

  assign ex_end = (phase_i == rv_pkg::ph_execute);

  // strobes last exactly the writeback cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retire_o <= 1'b0;
      rd_we_o  <= 1'b0;
      jmp_o    <= 1'b0;
    end else begin
      retire_o <= ex_end;
      rd_we_o  <= ex_end && rd_we_i;
      jmp_o    <= ex_end && taken_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_end) begin
      rd_addr_o  <= rd_addr_i;
      rd_data_o  <= result_i;
      jmp_addr_o <= target_i;
    end
  end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
// shared enums for the execute slice, referenced by scoped name from each module
`default_nettype none

package rv_pkg;

  // alu operation selected by decode
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // jump link value
  } alu_op_e;

  // branch conditions, encoded as their funct3
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_e;

  // instruction class, steers result and redirect
  typedef enum logic [1:0] {
    cls_alu,
    cls_branch,
    cls_jal,
    cls_jalr
  } inst_class_e;

  // one instruction in flight, one cycle per phase
  typedef enum logic [1:0] {
    ph_idle,
    ph_execute,
    ph_writeback
  } phase_e;

endpackage

`default_nettype wire

/* test/tb_exec_core.sv */
// directed testbench for exec_core, checks every retire against a register file model
`include "rv_defs.svh"
`default_nettype none

module tb_exec_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_INST     = 200;  // bound on instructions issued by all tests
  localparam int WATCHDOG_NS  = (RESET_CYCLES + MAX_INST * 4 + 100) * CLK_PERIOD;

  logic                   clk;
  logic                   rst_n_i;
  logic                   inst_valid_i;
  logic [31:0]            inst_i;
  logic [`XLEN_W-1:0]     pc_i;
  logic [`REG_ADDR_W-1:0] dbg_addr_i;
  logic                   busy_o, retire_o, rd_we_o, jmp_o;
  logic [`REG_ADDR_W-1:0] rd_addr_o;
  logic [`XLEN_W-1:0]     rd_data_o, jmp_addr_o, dbg_data_o;

  logic [63:0] model_rf [0:31];
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;

  exec_core uut (
    .clk(clk), .rst_n_i(rst_n_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
    .pc_i(pc_i), .dbg_addr_i(dbg_addr_i), .busy_o(busy_o), .retire_o(retire_o),
    .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o), .jmp_o(jmp_o),
    .jmp_addr_o(jmp_addr_o), .dbg_data_o(dbg_data_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand64(output logic [63:0] v);
    v = '0;
    for (int i = 0; i < 64; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // rv64i integer rules, word forms sign-extend bit 31
  function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic w, input logic [63:0] a,
                                          input logic [63:0] b);
    logic [63:0] r;
    logic [31:0] r32;
    int unsigned sh;
    sh = w ? b[4:0] : b[5:0];
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = {63'd0, $signed(a) < $signed(b)};
      3'd3: r = {63'd0, a < b};
      3'd4: r = a ^ b;
      3'd6: r = a | b;
      3'd7: r = a & b;
      default: begin
        r = a >> sh;
        if (alt) begin
          r = $signed(a) >>> sh;
        end
      end
    endcase
    if (w) begin
      r32 = r[31:0];  // add, sub, sll agree in the low half
      if (f3 == 3'd5) begin
        r32 = a[31:0] >> sh;
        if (alt) begin
          r32 = $signed(a[31:0]) >>> sh;
        end
      end
      r = {{32{r32[31]}}, r32};
    end
    return r;
  endfunction

  task automatic check_val(input string tname, input string what, input logic [63:0] exp,
                           input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s %s expected %h actual %h", tname, what, exp, act);
    end
  endtask

  task automatic check_flag(input string tname, input logic ok, input string msg);
    checks++;
    assert (ok === 1'b1) else begin
      errors++;
      $display("%s: %s", tname, msg);
    end
  endtask

  task automatic read_dbg(input logic [4:0] addr, output logic [63:0] v);
    dbg_addr_i = addr;
    #1;
    v = dbg_data_o;
  endtask

  // strobe one instruction, return in the retire cycle
  task automatic issue(input logic [31:0] inst, input logic [63:0] pc);
    @(posedge clk);
    #1;
    inst_valid_i = 1'b1;
    inst_i       = inst;
    pc_i         = pc;
    @(posedge clk);  // accepting edge
    #1;
    inst_valid_i = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic issue_check(input string tname, input logic [31:0] inst,
                             input logic [63:0] pc, input logic exp_we,
                             input logic [4:0] exp_rd, input logic [63:0] exp_data,
                             input logic exp_jmp, input logic [63:0] exp_target);
    logic [63:0] v;
    issue(inst, pc);
    check_flag(tname, retire_o, "retire_o not high two cycles after the strobe");
    check_val(tname, "rd_we_o", exp_we, rd_we_o);
    check_val(tname, "jmp_o", exp_jmp, jmp_o);
    if (exp_we) begin
      check_val(tname, "rd_addr_o", exp_rd, rd_addr_o);
      check_val(tname, "rd_data_o", exp_data, rd_data_o);
    end
    if (exp_jmp) begin
      check_val(tname, "jmp_addr_o", exp_target, jmp_addr_o);
    end
    @(posedge clk);  // write-back edge
    #1;
    check_flag(tname, !retire_o && !busy_o, "retire_o or busy_o stayed high after retire");
    if (exp_we && exp_rd != 5'd0) begin
      model_rf[exp_rd] = exp_data;
    end
    if (exp_we) begin
      read_dbg(exp_rd, v);
      check_val(tname, "debug read", model_rf[exp_rd], v);
    end
  endtask

  task automatic exec_alu(input logic [2:0] f3, input logic alt, input logic w,
                          input logic use_imm, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [11:0] imm);
    logic [11:0] field;
    logic [6:0]  opc;
    logic [63:0] b;
    field = imm;
    if (f3 == 3'd1 || f3 == 3'd5) begin
      field     = w ? {7'h00, imm[4:0]} : {6'h00, imm[5:0]};  // shamt
      field[10] = alt;
    end
    if (use_imm) begin
      opc = w ? `OPC_OP_IMM_32 : `OPC_OP_IMM;
      b   = {{52{imm[11]}}, imm};
    end else begin
      opc   = w ? `OPC_OP_32 : `OPC_OP;
      field = {alt ? 7'h20 : 7'h00, rs2};
      b     = model_rf[rs2];
    end
    issue_check($sformatf("alu f3=%0d alt=%0d word=%0d imm=%0d", f3, alt, w, use_imm),
                {field, rs1, f3, rd, opc}, 64'h1000, 1'b1, rd,
                ref_alu(f3, alt, w, model_rf[rs1], b), 1'b0, 64'd0);
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [63:0] value);
    logic [63:0] v;
    exec_alu(3'd0, 1'b0, 1'b0, 1'b1, rd, 5'd0, 5'd0, {4'h0, value[63:56]});
    for (int i = 6; i >= 0; i--) begin
      exec_alu(3'd1, 1'b0, 1'b0, 1'b1, rd, rd, 5'd0, 12'd8);
      exec_alu(3'd6, 1'b0, 1'b0, 1'b1, rd, rd, 5'd0, {4'h0, value[i*8 +: 8]});
    end
    read_dbg(rd, v);
    check_val("load", "loaded register", value, v);
  endtask

  task automatic exec_branch(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [12:0] off,
                             input logic [63:0] pc);
    logic [63:0] a;
    logic [63:0] b;
    logic        t;
    a = model_rf[rs1];
    b = model_rf[rs2];
    case (f3)
      3'd0:    t = (a == b);
      3'd1:    t = (a != b);
      3'd4:    t = ($signed(a) < $signed(b));
      3'd5:    t = ($signed(a) >= $signed(b));
      3'd6:    t = (a < b);
      default: t = (a >= b);
    endcase
    issue_check($sformatf("branch f3=%0d x%0d x%0d", f3, rs1, rs2),
                {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH}, pc,
                1'b0, 5'd0, 64'd0, t, pc + {{51{off[12]}}, off});
  endtask

  task automatic reset_state();
    logic [63:0] v;
    check_flag("reset", !busy_o && !retire_o && !jmp_o && !rd_we_o,
               "a status output is high after reset");
    for (int r = 0; r < 32; r++) begin
      read_dbg(5'(r), v);
      check_val("reset", $sformatf("x%0d", r), 64'd0, v);
    end
  endtask

  task automatic alu_ops();
    logic [63:0] v;
    logic [4:0]  ra, rb, rd;
    rand64(v);
    load_reg(5'd1, v & ~64'h8000_0000_0000_0000);  // positive
    rand64(v);
    load_reg(5'd2, v);
    rand64(v);
    load_reg(5'd3, v | 64'h8000_0000_0000_0000);  // negative
    rand64(v);
    load_reg(5'd4, v);
    for (int p = 0; p < 2; p++) begin
      ra = (p == 0) ? 5'd3 : 5'd2;
      rb = (p == 0) ? 5'd1 : 5'd4;
      rd = 5'(20 + p);
      for (int f = 0; f < 8; f++) begin
        rand64(v);
        exec_alu(3'(f), 1'b0, 1'b0, 1'b1, rd, ra, rb, v[11:0]);
        exec_alu(3'(f), 1'b0, 1'b0, 1'b0, rd, ra, rb, 12'd0);
      end
      exec_alu(3'd5, 1'b1, 1'b0, 1'b1, rd, ra, rb, v[23:12]);  // srai
      exec_alu(3'd0, 1'b1, 1'b0, 1'b0, rd, ra, rb, 12'd0);
      exec_alu(3'd5, 1'b1, 1'b0, 1'b0, rd, ra, rb, 12'd0);
    end
    exec_alu(3'd0, 1'b0, 1'b0, 1'b1, 5'd0, 5'd1, 5'd0, 12'h7FF);  // x0 stays zero
    exec_alu(3'd0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd3, 5'd4, 12'd0);
  endtask

  task automatic word_ops();
    logic [4:0] ra;
    exec_alu(3'd0, 1'b0, 1'b0, 1'b1, 5'd5, 5'd0, 5'd0, 12'hFE3);  // shift bits above 4 set
    exec_alu(3'd0, 1'b0, 1'b0, 1'b1, 5'd6, 5'd0, 5'd0, 12'd1);
    exec_alu(3'd1, 1'b0, 1'b0, 1'b1, 5'd6, 5'd6, 5'd0, 12'd31);
    exec_alu(3'd6, 1'b0, 1'b0, 1'b1, 5'd6, 5'd6, 5'd0, 12'h700);
    for (int k = 0; k < 2; k++) begin
      ra = (k == 0) ? 5'd3 : 5'd6;
      exec_alu(3'd0, 1'b0, 1'b1, 1'b1, 5'd22, ra, 5'd0, 12'h7F0);
      exec_alu(3'd1, 1'b0, 1'b1, 1'b1, 5'd22, ra, 5'd0, 12'h03C);
      exec_alu(3'd5, 1'b0, 1'b1, 1'b1, 5'd22, ra, 5'd0, 12'h024);
      exec_alu(3'd5, 1'b1, 1'b1, 1'b1, 5'd22, ra, 5'd0, 12'h024);
      exec_alu(3'd0, 1'b0, 1'b1, 1'b0, 5'd22, ra, 5'd2, 12'd0);
      exec_alu(3'd0, 1'b1, 1'b1, 1'b0, 5'd22, ra, 5'd5, 12'd0);
      exec_alu(3'd1, 1'b0, 1'b1, 1'b0, 5'd22, ra, 5'd5, 12'd0);
      exec_alu(3'd5, 1'b0, 1'b1, 1'b0, 5'd22, ra, 5'd5, 12'd0);
      exec_alu(3'd5, 1'b1, 1'b1, 1'b0, 5'd22, ra, 5'd5, 12'd0);
    end
    exec_alu(3'd5, 1'b1, 1'b0, 1'b0, 5'd22, 5'd3, 5'd5, 12'd0);  // 6-bit mask on 64-bit sra
  endtask

  task automatic branches();
    logic [63:0] pc;
    pc = 64'h0000_0000_0040_0000;
    exec_alu(3'd0, 1'b0, 1'b0, 1'b1, 5'd7, 5'd0, 5'd0, 12'hFFB);
    exec_alu(3'd0, 1'b0, 1'b0, 1'b1, 5'd8, 5'd0, 5'd0, 12'd7);
    exec_alu(3'd0, 1'b0, 1'b0, 1'b1, 5'd9, 5'd0, 5'd0, 12'hFFB);
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        exec_branch(3'(f), 5'd7, 5'd8, 13'h1F00, pc);  // sign-differing pair
        exec_branch(3'(f), 5'd8, 5'd7, 13'h0040, pc);
        exec_branch(3'(f), 5'd7, 5'd9, 13'h0FFE, pc);  // equal pair
      end
    end
  endtask

  task automatic jumps_auipc();
    logic [63:0] pc;
    logic [63:0] tgt;
    logic [20:0] off;
    logic [11:0] imm;
    logic [19:0] u;
    pc  = 64'h0000_0000_8000_1000;
    off = 21'h1F_F000;
    issue_check("jal", {off[20], off[10:1], off[11], off[19:12], 5'd10, `OPC_JAL}, pc,
                1'b1, 5'd10, pc + 64'd4, 1'b1, pc + {{43{off[20]}}, off});
    for (int k = 0; k < 2; k++) begin
      imm    = 12'h7FE + 12'(k);
      tgt    = model_rf[1] + {{52{imm[11]}}, imm};
      tgt[0] = 1'b0;
      issue_check("jalr", {imm, 5'd1, 3'b000, 5'd11, `OPC_JALR}, pc,
                  1'b1, 5'd11, pc + 64'd4, 1'b1, tgt);
    end
    for (int k = 0; k < 2; k++) begin
      u = (k == 0) ? 20'h8_0123 : 20'h1_2345;
      issue_check("auipc", {u, 5'd12, `OPC_AUIPC}, pc, 1'b1, 5'd12,
                  pc + {{32{u[19]}}, u, 12'h000}, 1'b0, 64'd0);
    end
  endtask

  task automatic busy_strobe();
    logic [63:0] v;
    int          retires;
    retires = 0;
    @(posedge clk);
    #1;
    inst_valid_i = 1'b1;
    inst_i       = {12'h123, 5'd0, 3'd0, 5'd14, `OPC_OP_IMM};
    @(posedge clk);
    #1;
    check_flag("busy strobe", busy_o, "busy_o low after an accepted strobe");
    inst_i = {12'h456, 5'd0, 3'd0, 5'd15, `OPC_OP_IMM};  // held through the busy cycles
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      #1;
      if (c == 1) begin
        inst_valid_i = 1'b0;
      end
      if (retire_o) begin
        retires++;
        check_val("busy strobe", "rd_addr_o", 64'd14, rd_addr_o);
        check_val("busy strobe", "rd_data_o", 64'h123, rd_data_o);
      end
    end
    check_val("busy strobe", "retire count", 64'd1, retires);
    model_rf[14] = 64'h123;
    read_dbg(5'd14, v);
    check_val("busy strobe", "x14", model_rf[14], v);
    read_dbg(5'd15, v);
    check_val("busy strobe", "x15", model_rf[15], v);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    dbg_addr_i   = '0;
    errors       = 0;
    checks       = 0;
    lfsr_state   = 32'd6;
    for (int r = 0; r < 32; r++) begin
      model_rf[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    reset_state();
    alu_ops();
    word_ops();
    branches();
    jumps_auipc();
    busy_strobe();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
